// ==== source/softmax_settings.svh ====
/* softmax engine settings
   sample format, vector geometry and fixed-point constants */
`ifndef SOFTMAX_SETTINGS_SVH
`define SOFTMAX_SETTINGS_SVH

// sample width, signed Q16.16
`define SOFTMAX_WIDTH 32

// fraction bits of a sample
`define SOFTMAX_FRAC 16

// elements in one input vector
`define SOFTMAX_TOTAL 18

// lanes per tile, element 0 in the top lane
`define SOFTMAX_TILE 4

// tiles per vector, last one may be partly filled
`define SOFTMAX_NUM_TILES ((`SOFTMAX_TOTAL + `SOFTMAX_TILE - 1) / `SOFTMAX_TILE)

// ln 2 in Q16.16
`define SOFTMAX_LN2_Q 32'h0000_B172

// log2 e in Q16.16
`define SOFTMAX_LOG2E_Q 32'h0001_7154

`endif

// ==== source/softmax_pkg.sv ====
/* softmax engine types
   sample, tile, sum and address vectors plus the pass state encoding */
`default_nettype none

`include "softmax_settings.svh"

package softmax_pkg;

    // one signed Q16.16 element
    typedef logic signed [`SOFTMAX_WIDTH-1:0] sample_t;

    // all lanes of a tile, element 0 in the top lane
    typedef logic [`SOFTMAX_TILE*`SOFTMAX_WIDTH-1:0] tile_t;

    // exp sum, wide enough for every element at 1.0
    typedef logic [`SOFTMAX_WIDTH+$clog2(`SOFTMAX_TOTAL+1)-1:0] sum_t;

    // tile buffer word address
    typedef logic [$clog2(`SOFTMAX_NUM_TILES)-1:0] tile_addr_t;

    // element index, covers padding lanes of the last tile
    typedef logic [$clog2(`SOFTMAX_TOTAL+`SOFTMAX_TILE)-1:0] elem_count_t;

    // pass sequence of the controller
    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_sum,
        st_log,
        st_emit,
        st_done
    } softmax_state_e;

endpackage

`default_nettype wire

// ==== source/tile_buffer.sv ====
/* tile buffer
   one write port and one registered read port, one tile per word */
`default_nettype none

`include "softmax_settings.svh"

module tile_buffer import softmax_pkg::*; (
    input  logic       clk,
    input  logic       we,
    input  tile_addr_t wr_addr,
    input  tile_t      wr_tile,
    input  tile_addr_t rd_addr,
    output tile_t      rd_tile
);

    // one word per tile of the vector
    tile_t mem [`SOFTMAX_NUM_TILES];

    // write side, load pass only
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_tile;
        end
    end

    // registered read, data one cycle after the address
    // maps onto block RAM output register
    always_ff @(posedge clk) begin
        rd_tile <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== source/exp_tile.sv ====
/* exp tile unit
   per-lane exp of lane minus offset via base-2 split, one register stage */
`default_nettype none

`include "softmax_settings.svh"

module exp_tile import softmax_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  tile_t   in_tile,
    input  sample_t offset,
    output logic    out_valid,
    output tile_t   out_tile
);

    localparam int W = `SOFTMAX_WIDTH;
    localparam int F = `SOFTMAX_FRAC;
    localparam sample_t ONE_Q = sample_t'(1 << F);

    tile_t exp_next;

    // exp(x - off) = 2^-(n + f), with 2^-f taken as 1 - f/2
    function automatic sample_t lane_exp(input sample_t x, input sample_t off);
        logic signed [W:0] diff;
        logic [W:0] neg_d;
        logic [2*W:0] prod;
        logic [2*W-2*F:0] n_int;
        logic [F-1:0] f_frac;
        sample_t mant;
        // one extra bit so the difference never wraps
        diff = (W+1)'(x) - (W+1)'(off);
        // clamp d to at most zero
        if (diff > 0) begin
            neg_d = '0;
        end else begin
            neg_d = -diff;
        end
        // t = -d * log2e, kept with two fraction fields
        prod = neg_d * `SOFTMAX_LOG2E_Q;
        n_int = prod[2*W:2*F];
        f_frac = prod[2*F-1:F];
        mant = ONE_Q - sample_t'(f_frac >> 1);
        // shifted out completely
        if (n_int >= 31) begin
            return '0;
        end
        return mant >> n_int;
    endfunction

    // lane order does not matter here, every lane gets the same rule
    always_comb begin
        for (int i = 0; i < `SOFTMAX_TILE; i++) begin
            exp_next[i*W +: W] = lane_exp(in_tile[i*W +: W], offset);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // result lanes, only loaded on a valid tile
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_tile <= exp_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/ln_unit.sv ====
/* natural log of the exp sum
   leading-one range reduction with a linear log of the mantissa */
`default_nettype none

`include "softmax_settings.svh"

module ln_unit import softmax_pkg::*; (
    input  sum_t    sum_exp,
    output sample_t ln_sum
);

    localparam int F = `SOFTMAX_FRAC;
    localparam int SW = $bits(sum_t);

    int lead_pos;
    int k_exp;
    sum_t norm;
    logic [F-1:0] mant_frac;
    logic [2*F-1:0] frac_prod;
    sample_t k_term;

    always_comb begin
        // highest set bit wins
        lead_pos = 0;
        for (int i = 0; i < SW; i++) begin
            if (sum_exp[i]) begin
                lead_pos = i;
            end
        end
        // sum = 2^k * (1 + m) in Q16.16
        k_exp = lead_pos - F;
        // move the leading one to bit F
        if (lead_pos >= F) begin
            norm = sum_exp >> (lead_pos - F);
        end else begin
            norm = sum_exp << (F - lead_pos);
        end
        // 16 bits right below the leading one
        mant_frac = norm[F-1:0];
        // ln(1 + m) taken as m * ln2
        frac_prod = mant_frac * `SOFTMAX_LN2_Q;
        // k may be negative for sums under 1.0
        k_term = sample_t'(k_exp * int'(`SOFTMAX_LN2_Q));
        ln_sum = k_term + sample_t'(frac_prod >> F);
    end

endmodule

`default_nettype wire

// ==== source/softmax_ctrl.sv ====
/* softmax pass controller
   load, sum, log and emit passes with max tracking, sum and lane masking */
`default_nettype none

`include "softmax_settings.svh"

module softmax_ctrl import softmax_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       tile_in_valid,
    input  tile_t      x_tile,
    output logic       buf_we,
    output tile_addr_t buf_wr_addr,
    output tile_addr_t buf_rd_addr,
    output logic       exp_in_valid,
    output sample_t    exp_offset,
    input  logic       exp_out_valid,
    input  tile_t      exp_out,
    input  sample_t    ln_sum,
    output sum_t       sum_exp,
    output tile_t      y_tile,
    output logic       tile_out_valid,
    output logic       done
);

    localparam int W = `SOFTMAX_WIDTH;
    localparam int TILE = `SOFTMAX_TILE;
    localparam tile_addr_t LAST_TILE = tile_addr_t'(`SOFTMAX_NUM_TILES - 1);
    localparam sample_t SAMPLE_MIN = {1'b1, {(W-1){1'b0}}};

    softmax_state_e state;
    tile_addr_t load_idx;
    tile_addr_t rd_addr;
    tile_addr_t res_idx;
    logic issue_on;
    logic issue_q;
    logic last_res;
    sample_t max_val;
    sample_t tile_max;
    sample_t ln_reg;
    sum_t tile_sum;
    logic [TILE-1:0] load_ok;
    logic [TILE-1:0] res_ok;

    // lane holds a real element, not padding
    function automatic logic lane_in_range(input tile_addr_t idx, input int lane);
        elem_count_t elem;
        elem = elem_count_t'(int'(idx) * TILE + lane);
        return elem < `SOFTMAX_TOTAL;
    endfunction

    // lane 0 sits in the top bits
    function automatic sample_t lane_of(input tile_t t, input int lane);
        return t[(TILE-1-lane)*W +: W];
    endfunction

    assign last_res = exp_out_valid && (res_idx == LAST_TILE);
    assign buf_we = (state == st_load) && tile_in_valid;
    assign buf_wr_addr = load_idx;
    assign buf_rd_addr = rd_addr;
    // buffer data lines up with the delayed issue flag
    assign exp_in_valid = issue_q;
    assign exp_offset = (state == st_emit) ? max_val + ln_reg : max_val;
    assign tile_out_valid = (state == st_emit) && exp_out_valid;
    assign done = (state == st_done);

    always_comb begin
        for (int i = 0; i < TILE; i++) begin
            load_ok[i] = lane_in_range(load_idx, i);
            res_ok[i] = lane_in_range(res_idx, i);
        end
    end

    // running max folded with the incoming tile
    always_comb begin
        tile_max = max_val;
        for (int i = 0; i < TILE; i++) begin
            if (load_ok[i] && (lane_of(x_tile, i) > tile_max)) begin
                tile_max = lane_of(x_tile, i);
            end
        end
    end

    // valid lanes summed, padding lanes zeroed at the output
    always_comb begin
        tile_sum = '0;
        y_tile = exp_out;
        for (int i = 0; i < TILE; i++) begin
            if (res_ok[i]) begin
                tile_sum = tile_sum + sum_t'($unsigned(lane_of(exp_out, i)));
            end else begin
                y_tile[(TILE-1-i)*W +: W] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            load_idx <= '0;
            rd_addr <= '0;
            res_idx <= '0;
            issue_on <= 1'b0;
            issue_q <= 1'b0;
            max_val <= SAMPLE_MIN;
            sum_exp <= '0;
        end else begin
            issue_q <= issue_on;
            // one read per cycle until the last tile
            if (issue_on) begin
                if (rd_addr == LAST_TILE) begin
                    issue_on <= 1'b0;
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
            // tile index of the returning exp result
            if (exp_out_valid) begin
                res_idx <= res_idx + 1'b1;
            end
            case (state)
                st_idle, st_done: begin
                    if (start) begin
                        state <= st_load;
                        load_idx <= '0;
                        max_val <= SAMPLE_MIN;
                        sum_exp <= '0;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_load: begin
                    if (tile_in_valid) begin
                        max_val <= tile_max;
                        load_idx <= load_idx + 1'b1;
                        if (load_idx == LAST_TILE) begin
                            state <= st_sum;
                            issue_on <= 1'b1;
                            rd_addr <= '0;
                            res_idx <= '0;
                        end
                    end
                end
                st_sum: begin
                    if (exp_out_valid) begin
                        sum_exp <= sum_exp + tile_sum;
                    end
                    if (last_res) begin
                        state <= st_log;
                    end
                end
                // ln of the final sum is latched here
                st_log: begin
                    state <= st_emit;
                    issue_on <= 1'b1;
                    rd_addr <= '0;
                    res_idx <= '0;
                end
                st_emit: begin
                    if (last_res) begin
                        state <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // ln offset for the emit pass
    always_ff @(posedge clk) begin
        if (state == st_log) begin
            ln_reg <= ln_sum;
        end
    end

endmodule

`default_nettype wire

// ==== source/softmax_top.sv ====
/* streaming softmax engine
   controller, tile buffer, exp tile unit and ln unit */
`default_nettype none

`include "softmax_settings.svh"

module softmax_top import softmax_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  tile_t x_tile,
    input  logic  tile_in_valid,
    output tile_t y_tile,
    output logic  tile_out_valid,
    output logic  done
);

    // buffer side
    logic buf_we;
    tile_addr_t buf_wr_addr;
    tile_addr_t buf_rd_addr;
    tile_t rd_tile;
    // exp and ln side
    logic exp_in_valid;
    logic exp_out_valid;
    sample_t exp_offset;
    tile_t exp_out;
    sum_t sum_exp;
    sample_t ln_sum;

    softmax_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .tile_in_valid  (tile_in_valid),
        .x_tile         (x_tile),
        .buf_we         (buf_we),
        .buf_wr_addr    (buf_wr_addr),
        .buf_rd_addr    (buf_rd_addr),
        .exp_in_valid   (exp_in_valid),
        .exp_offset     (exp_offset),
        .exp_out_valid  (exp_out_valid),
        .exp_out        (exp_out),
        .ln_sum         (ln_sum),
        .sum_exp        (sum_exp),
        .y_tile         (y_tile),
        .tile_out_valid (tile_out_valid),
        .done           (done)
    );

    tile_buffer u_buf (
        .clk     (clk),
        .we      (buf_we),
        .wr_addr (buf_wr_addr),
        .wr_tile (x_tile),
        .rd_addr (buf_rd_addr),
        .rd_tile (rd_tile)
    );

    // buffer output feeds the exp unit directly
    exp_tile u_exp (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (exp_in_valid),
        .in_tile   (rd_tile),
        .offset    (exp_offset),
        .out_valid (exp_out_valid),
        .out_tile  (exp_out)
    );

    ln_unit u_ln (
        .sum_exp (sum_exp),
        .ln_sum  (ln_sum)
    );

endmodule

`default_nettype wire

// ==== testbench/softmax_ref.svh ====
/* softmax reference model
   exp, ln and full softmax on the engine's fixed-point formats */
`ifndef SOFTMAX_REF_SVH
`define SOFTMAX_REF_SVH

`include "softmax_settings.svh"

// whole vector as tiles, tile 0 in the low bits
typedef logic [`SOFTMAX_NUM_TILES*`SOFTMAX_TILE*`SOFTMAX_WIDTH-1:0] vector_t;

// exp(x - off) = 2^-(n + f), 2^-f taken as 1 - f/2
function automatic sample_t ref_exp(input sample_t x, input sample_t off);
    longint d;
    longint t;
    longint n;
    longint f;
    longint mant;
    d = longint'(x) - longint'(off);
    // only non-positive exponents
    if (d > 0) begin
        d = 0;
    end
    t = ((-d) * longint'(`SOFTMAX_LOG2E_Q)) >>> `SOFTMAX_FRAC;
    n = t >>> `SOFTMAX_FRAC;
    f = t & 64'hFFFF;
    mant = (64'sd1 <<< `SOFTMAX_FRAC) - (f >>> 1);
    if (n >= 31) begin
        return '0;
    end
    return sample_t'(mant >>> n);
endfunction

// ln(s) = k ln2 + m ln2, m the 16 bits under the leading one
function automatic sample_t ref_ln(input sum_t s);
    int lead;
    longint k;
    longint m;
    longint wide;
    lead = 0;
    wide = longint'(s);
    for (int i = 0; i < $bits(sum_t); i++) begin
        if (s[i]) begin
            lead = i;
        end
    end
    k = lead - `SOFTMAX_FRAC;
    if (lead >= `SOFTMAX_FRAC) begin
        m = (wide >>> (lead - `SOFTMAX_FRAC)) & 64'hFFFF;
    end else begin
        m = (wide <<< (`SOFTMAX_FRAC - lead)) & 64'hFFFF;
    end
    return sample_t'(k * longint'(`SOFTMAX_LN2_Q)
        + ((m * longint'(`SOFTMAX_LN2_Q)) >>> `SOFTMAX_FRAC));
endfunction

// element e of the vector, lane 0 in the top bits of its tile
function automatic sample_t ref_elem(input vector_t vec, input int e);
    tile_t t;
    t = vec[(e / `SOFTMAX_TILE) * $bits(tile_t) +: $bits(tile_t)];
    return t[(`SOFTMAX_TILE - 1 - e % `SOFTMAX_TILE) * `SOFTMAX_WIDTH +: `SOFTMAX_WIDTH];
endfunction

// one output tile, padding lanes zero
function automatic tile_t ref_softmax(input vector_t vec, input int tile_idx);
    sample_t mx;
    sample_t off;
    sum_t s;
    tile_t y;
    int e;
    mx = {1'b1, {(`SOFTMAX_WIDTH-1){1'b0}}};
    for (int i = 0; i < `SOFTMAX_TOTAL; i++) begin
        if (ref_elem(vec, i) > mx) begin
            mx = ref_elem(vec, i);
        end
    end
    s = '0;
    for (int i = 0; i < `SOFTMAX_TOTAL; i++) begin
        s = s + sum_t'($unsigned(ref_exp(ref_elem(vec, i), mx)));
    end
    // log folded into the offset, wraps like a sample
    off = mx + ref_ln(s);
    y = '0;
    for (int lane = 0; lane < `SOFTMAX_TILE; lane++) begin
        e = tile_idx * `SOFTMAX_TILE + lane;
        if (e < `SOFTMAX_TOTAL) begin
            y[(`SOFTMAX_TILE-1-lane)*`SOFTMAX_WIDTH +: `SOFTMAX_WIDTH] =
                ref_exp(ref_elem(vec, e), off);
        end
    end
    return y;
endfunction

`endif

// ==== testbench/tb_softmax.sv ====
/* softmax engine testbench
   directed passes over random, padded, equal and interrupted vectors */
`default_nettype none

`include "softmax_settings.svh"

module tb_softmax import softmax_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    `include "softmax_ref.svh"

    localparam int W = `SOFTMAX_WIDTH;
    localparam int TILE = `SOFTMAX_TILE;
    localparam int NT = `SOFTMAX_NUM_TILES;
    localparam int TOTAL = `SOFTMAX_TOTAL;
    localparam int TB = $bits(tile_t);
    localparam int NUM_TESTS = 6;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 4 * (NT + 10);
    // sum, log and emit passes fit well inside this
    localparam int CAPTURE_LIMIT = 3 * NT + 20;

    logic clk = 1'b0;
    logic rst_n;
    logic start;
    tile_t x_tile;
    logic tile_in_valid;
    tile_t y_tile;
    logic tile_out_valid;
    logic done;

    int mismatch_count = 0;
    int fail_count = 0;
    logic [31:0] lcg_state = 32'd39;
    tile_t exp_tiles [NT];

    softmax_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .x_tile         (x_tile),
        .tile_in_valid  (tile_in_valid),
        .y_tile         (y_tile),
        .tile_out_valid (tile_out_valid),
        .done           (done)
    );

    always #5 clk = ~clk;

    // samples spread over about +-8.0
    function automatic sample_t next_sample();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return sample_t'(int'(lcg_state[30:11]) - 524288);
    endfunction

    // bit offset of element e inside a vector
    function automatic int elem_pos(input int e);
        return (e / TILE) * TB + (TILE - 1 - e % TILE) * W;
    endfunction

    function automatic vector_t random_vector();
        vector_t v;
        for (int i = 0; i < NT * TILE; i++) begin
            v[i*W +: W] = next_sample();
        end
        return v;
    endfunction

    task automatic compare_tile(input tile_t got, input tile_t exp, input string msg);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic set_expected(input vector_t vec);
        for (int t = 0; t < NT; t++) begin
            exp_tiles[t] = ref_softmax(vec, t);
        end
    endtask

    // rst_n seen low on two edges
    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic send_start();
        @(posedge clk);
        start <= 1'b1;
    endtask

    // one tile per cycle, start dropped with the first
    task automatic send_tiles(input vector_t vec);
        for (int t = 0; t < NT; t++) begin
            @(posedge clk);
            start <= 1'b0;
            tile_in_valid <= 1'b1;
            x_tile <= vec[t*TB +: TB];
        end
        @(posedge clk);
        tile_in_valid <= 1'b0;
        x_tile <= '0;
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare_flag(tile_out_valid, 1'b0, "tile_out_valid while quiet");
            compare_flag(done, 1'b0, "done while quiet");
        end
    endtask

    // checks every output tile, consecutive strobes and a single done
    // inject_start pulses start during emit, chain_start restarts from done
    task automatic capture_outputs(input bit inject_start, input bit chain_start);
        int n_out;
        int last_cyc;
        int cyc;
        bit finished;
        bit want_start;
        n_out = 0;
        last_cyc = -2;
        cyc = 0;
        finished = 1'b0;
        while (!finished && cyc < CAPTURE_LIMIT) begin
            @(negedge clk);
            want_start = 1'b0;
            // done only on the cycle right after the last tile
            compare_flag(done, (n_out == NT) && (cyc == last_cyc + 1), "done strobe");
            if ((n_out == NT) && (cyc >= last_cyc + 1)) begin
                finished = 1'b1;
            end
            if (tile_out_valid) begin
                if (n_out >= NT) begin
                    fail_count++;
                    $display("extra output tile at %0t", $time);
                end else begin
                    if (n_out > 0 && cyc != last_cyc + 1) begin
                        fail_count++;
                        $display("gap before output tile %0d at %0t", n_out, $time);
                    end
                    compare_tile(y_tile, exp_tiles[n_out], $sformatf("output tile %0d", n_out));
                end
                n_out++;
                last_cyc = cyc;
                want_start = (inject_start && n_out == 1) || (chain_start && n_out == NT);
            end
            cyc++;
            if (want_start) begin
                @(posedge clk);
                start <= 1'b1;
            end else if (start && !(chain_start && finished)) begin
                @(posedge clk);
                start <= 1'b0;
            end
        end
        if (!finished) begin
            fail_count++;
            $display("no done pulse after %0d output tiles, expected %0d tiles", n_out, NT);
        end else if (!chain_start) begin
            @(negedge clk);
            compare_flag(done, 1'b0, "done after its pulse");
        end
    endtask

    task automatic run_vector(input vector_t sent, input vector_t ref_src);
        set_expected(ref_src);
        send_start();
        send_tiles(sent);
        capture_outputs(1'b0, 1'b0);
    endtask

    task automatic test_random_vector();
        vector_t vec;
        vec = random_vector();
        run_vector(vec, vec);
    endtask

    // nothing strobes before start, then the strobe pattern of one run
    task automatic test_strobe_count();
        vector_t vec;
        vec = random_vector();
        check_quiet(4);
        run_vector(vec, vec);
    endtask

    task automatic test_padding_ignored();
        vector_t vec;
        vector_t clean;
        vec = random_vector();
        clean = vec;
        for (int e = TOTAL; e < NT * TILE; e++) begin
            vec[elem_pos(e) +: W] = 32'h7FFF_0000;
            clean[elem_pos(e) +: W] = '0;
        end
        run_vector(vec, clean);
    endtask

    task automatic test_equal_inputs();
        vector_t vec;
        sample_t val;
        sample_t one_val;
        sum_t s;
        int e;
        val = 32'h0002_8000;
        for (int i = 0; i < NT * TILE; i++) begin
            vec[elem_pos(i) +: W] = val;
        end
        // every element gives exp(0), so the sum is a plain multiple
        s = sum_t'(TOTAL) * sum_t'($unsigned(ref_exp(val, val)));
        one_val = ref_exp(val, val + ref_ln(s));
        for (int t = 0; t < NT; t++) begin
            for (int lane = 0; lane < TILE; lane++) begin
                e = t * TILE + lane;
                exp_tiles[t][(TILE-1-lane)*W +: W] = (e < TOTAL) ? one_val : '0;
            end
        end
        send_start();
        send_tiles(vec);
        capture_outputs(1'b0, 1'b0);
    endtask

    task automatic test_back_to_back();
        vector_t vec_a;
        vector_t vec_b;
        vec_a = random_vector();
        vec_b = random_vector();
        // stray tile while idle must not reach the buffer
        @(posedge clk);
        tile_in_valid <= 1'b1;
        x_tile <= {TILE{32'h7FFF_0000}};
        @(posedge clk);
        tile_in_valid <= 1'b0;
        x_tile <= '0;
        check_quiet(2);
        set_expected(vec_a);
        send_start();
        send_tiles(vec_a);
        capture_outputs(1'b1, 1'b1);
        // start already high in the done cycle
        set_expected(vec_b);
        send_tiles(vec_b);
        capture_outputs(1'b0, 1'b0);
    endtask

    task automatic test_reset_midrun();
        vector_t vec_a;
        vector_t vec_b;
        vec_a = random_vector();
        vec_b = random_vector();
        send_start();
        send_tiles(vec_a);
        // sum pass is running by now
        repeat (2) @(posedge clk);
        apply_reset();
        check_quiet(CAPTURE_LIMIT);
        run_vector(vec_b, vec_b);
    endtask

    initial begin
        start <= 1'b0;
        tile_in_valid <= 1'b0;
        x_tile <= '0;
        apply_reset();
        test_random_vector();
        test_strobe_count();
        test_padding_ignored();
        test_equal_inputs();
        test_back_to_back();
        test_reset_midrun();
        $display("%0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
+incdir+testbench
source/softmax_pkg.sv
source/tile_buffer.sv
source/exp_tile.sv
source/ln_unit.sv
source/softmax_ctrl.sv
source/softmax_top.sv
testbench/tb_softmax.sv
